// File: design/boot_ctrl.sv
`timescale 1ns/1ns

module boot_ctrl #(
   parameter int SRAM_ADDR_W    = 12,
   parameter int BOOTROM_ADDR_W = 8
) (
   input  logic                           clk_i,
   input  logic                           rst_n_i,
   input  int_mem_pkg::bus_req_t          cpu_req_i,
   input  logic [int_mem_pkg::DATA_W-1:0] rom_rdata_i,
   output int_mem_pkg::bus_resp_t         cpu_resp_o,
   output int_mem_pkg::bus_req_t          sram_req_o,
   output logic                           rom_valid_o,
   output logic [BOOTROM_ADDR_W-3:0]      rom_addr_o,
   output logic                           boot_o,
   output logic                           cpu_rst_o
);
   import int_mem_pkg::*;

   localparam int SRAM_AW = SRAM_ADDR_W - 2;
   localparam int ROM_AW  = BOOTROM_ADDR_W - 2;
   // first SRAM word of the region that receives the ROM image
   localparam logic [SRAM_AW-1:0] TOP_BASE = SRAM_AW'((2 ** SRAM_AW) - (2 ** ROM_AW));

   typedef enum logic [1:0] {
      ST_COPY,
      ST_HOLD,
      ST_RUN
   } state_t;

   state_t            state_q;
   logic [ROM_AW-1:0] rd_cnt_q;
   logic              rd_done_q;
   logic              wr_valid_q;
   logic [ROM_AW-1:0] wr_idx_q;
   logic [1:0]        hold_cnt_q;
   logic              boot_q;
   logic              rvalid_q;
   logic              rdata_q;
   logic              last_wr;
   logic              cpu_wr;
   logic              cpu_rd;

   // rom read side of the copy pipeline
   assign rom_valid_o = (state_q == ST_COPY) && !rd_done_q;
   assign rom_addr_o  = rd_cnt_q;

   assign last_wr = wr_valid_q && (wr_idx_q == '1);

   // register writes are ignored while the copy runs
   assign cpu_wr = cpu_req_i.valid && (cpu_req_i.wstrb != '0) && (state_q != ST_COPY);
   assign cpu_rd = cpu_req_i.valid && (cpu_req_i.wstrb == '0);

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         rd_cnt_q   <= '0;
         rd_done_q  <= 1'b0;
         wr_valid_q <= 1'b0;
      end else begin
         wr_valid_q <= rom_valid_o;
         if (rom_valid_o) begin
            rd_cnt_q <= rd_cnt_q + 1'b1;
            if (rd_cnt_q == '1) begin
               rd_done_q <= 1'b1;
            end
         end
      end
   end

   // word index trails the rom address by one cycle
   always_ff @(posedge clk_i) begin
      if (rom_valid_o) begin
         wr_idx_q <= rd_cnt_q;
      end
   end

   // sram write of the word the rom returns this cycle
   always_comb begin
      sram_req_o       = '0;
      sram_req_o.valid = wr_valid_q;
      sram_req_o.addr[SRAM_ADDR_W-1:0] = {TOP_BASE + SRAM_AW'(wr_idx_q), 2'b00};
      sram_req_o.wdata = rom_rdata_i;
      sram_req_o.wstrb = '1;
   end

   // copy, then run; a register write goes through a 4 cycle reset hold
   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         state_q    <= ST_COPY;
         hold_cnt_q <= '0;
         boot_q     <= 1'b1;
      end else begin
         case (state_q)
            ST_COPY: begin
               if (last_wr) begin
                  state_q <= ST_RUN;
               end
            end
            ST_HOLD: begin
               hold_cnt_q <= hold_cnt_q + 1'b1;
               if (hold_cnt_q == 2'd3) begin
                  state_q <= ST_RUN;
               end
            end
            default: ;
         endcase
         if (cpu_wr) begin
            boot_q     <= cpu_req_i.wdata[0];
            state_q    <= ST_HOLD;
            hold_cnt_q <= '0;
         end
      end
   end

   assign cpu_rst_o = (state_q != ST_RUN);
   assign boot_o    = boot_q;

   // boot flag readback
   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         rvalid_q <= 1'b0;
      end else begin
         rvalid_q <= cpu_rd;
      end
   end

   always_ff @(posedge clk_i) begin
      if (cpu_rd) begin
         rdata_q <= boot_q;
      end
   end

   always_comb begin
      cpu_resp_o.rdata  = {{(DATA_W-1){1'b0}}, rdata_q};
      cpu_resp_o.rvalid = rvalid_q;
      cpu_resp_o.ready  = 1'b1;
   end

   // sram writes only while the copy runs
   a_wr_in_copy : assert property (@(posedge clk_i) disable iff (!rst_n_i)
      sram_req_o.valid |-> (state_q == ST_COPY));

endmodule

// File: design/bus_split.sv
`timescale 1ns/1ns

module bus_split #(
   parameter int B_BIT = 31
) (
   input  logic                   clk_i,
   input  logic                   rst_n_i,
   input  int_mem_pkg::bus_req_t  m_req_i,
   input  int_mem_pkg::bus_resp_t s0_resp_i,
   input  int_mem_pkg::bus_resp_t s1_resp_i,
   output int_mem_pkg::bus_resp_t m_resp_o,
   output int_mem_pkg::bus_req_t  s0_req_o,
   output int_mem_pkg::bus_req_t  s1_req_o
);

   logic sel;
   logic m_rd_acc;
   // slave that took the last read
   logic rd_sel_q;

   assign sel = m_req_i.addr[B_BIT];

   // only the addressed slave sees valid
   always_comb begin
      s0_req_o       = m_req_i;
      s0_req_o.valid = m_req_i.valid && !sel;
      s1_req_o       = m_req_i;
      s1_req_o.valid = m_req_i.valid && sel;
   end

   assign m_rd_acc = m_req_i.valid && m_resp_o.ready && (m_req_i.wstrb == '0);

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         rd_sel_q <= 1'b0;
      end else if (m_rd_acc) begin
         rd_sel_q <= sel;
      end
   end

   // ready follows the live selection, read data the registered one
   always_comb begin
      m_resp_o.ready = sel ? s1_resp_i.ready : s0_resp_i.ready;
      if (rd_sel_q) begin
         m_resp_o.rdata  = s1_resp_i.rdata;
         m_resp_o.rvalid = s1_resp_i.rvalid;
      end else begin
         m_resp_o.rdata  = s0_resp_i.rdata;
         m_resp_o.rvalid = s0_resp_i.rvalid;
      end
   end

   // the slaves share one master, so their answers never overlap
   a_one_rvalid : assert property (@(posedge clk_i) disable iff (!rst_n_i)
      !(s0_resp_i.rvalid && s1_resp_i.rvalid));

endmodule

// File: design/dp_sram.sv
`timescale 1ns/1ns

module dp_sram #(
   parameter int SRAM_ADDR_W = 12
) (
   input  logic                   clk_i,
   input  logic                   rst_n_i,
   input  int_mem_pkg::bus_req_t  i_req_i,
   input  int_mem_pkg::bus_req_t  d_req_i,
   output int_mem_pkg::bus_resp_t i_resp_o,
   output int_mem_pkg::bus_resp_t d_resp_o
);
   import int_mem_pkg::*;

   localparam int WORD_AW = SRAM_ADDR_W - 2;
   localparam int DEPTH   = 2 ** WORD_AW;

   logic [DATA_W-1:0]  mem [DEPTH];
   logic [WORD_AW-1:0] i_addr;
   logic [WORD_AW-1:0] d_addr;
   logic               i_we;
   logic               i_re;
   logic               d_we;
   logic               d_re;
   logic [DATA_W-1:0]  i_rdata_q;
   logic [DATA_W-1:0]  d_rdata_q;
   logic               i_rvalid_q;
   logic               d_rvalid_q;

   // both ports arrive word addressed
   assign i_addr = i_req_i.addr[WORD_AW-1:0];
   assign d_addr = d_req_i.addr[WORD_AW-1:0];

   assign i_we = i_req_i.valid && (i_req_i.wstrb != '0);
   assign i_re = i_req_i.valid && (i_req_i.wstrb == '0);
   assign d_re = d_req_i.valid && (d_req_i.wstrb == '0);
   // instruction port keeps the word on a same-address write collision
   assign d_we = d_req_i.valid && (d_req_i.wstrb != '0) && !(i_we && (i_addr == d_addr));

   always_ff @(posedge clk_i) begin
      for (int b = 0; b < STRB_W; b++) begin
         if (d_we && d_req_i.wstrb[b]) begin
            mem[d_addr][8*b +: 8] <= d_req_i.wdata[8*b +: 8];
         end
         if (i_we && i_req_i.wstrb[b]) begin
            mem[i_addr][8*b +: 8] <= i_req_i.wdata[8*b +: 8];
         end
      end
      if (i_re) begin
         i_rdata_q <= mem[i_addr];
      end
      if (d_re) begin
         d_rdata_q <= mem[d_addr];
      end
   end

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         i_rvalid_q <= 1'b0;
         d_rvalid_q <= 1'b0;
      end else begin
         i_rvalid_q <= i_re;
         d_rvalid_q <= d_re;
      end
   end

   // no wait states on either port
   always_comb begin
      i_resp_o.rdata  = i_rdata_q;
      i_resp_o.rvalid = i_rvalid_q;
      i_resp_o.ready  = 1'b1;
      d_resp_o.rdata  = d_rdata_q;
      d_resp_o.rvalid = d_rvalid_q;
      d_resp_o.ready  = 1'b1;
   end

endmodule

// File: design/ibus_merge.sv
`timescale 1ns/1ns

module ibus_merge (
   input  logic                   clk_i,
   input  logic                   rst_n_i,
   input  int_mem_pkg::bus_req_t  hi_req_i,
   input  int_mem_pkg::bus_req_t  lo_req_i,
   input  int_mem_pkg::bus_resp_t s_resp_i,
   output int_mem_pkg::bus_resp_t hi_resp_o,
   output int_mem_pkg::bus_resp_t lo_resp_o,
   output int_mem_pkg::bus_req_t  s_req_o
);

   logic hi_sel;
   logic s_rd_acc;
   // master whose read is in flight
   logic owner_q;

   // high priority master takes the port whenever it asks
   assign hi_sel = hi_req_i.valid;

   always_comb begin
      s_req_o = hi_sel ? hi_req_i : lo_req_i;
   end

   assign s_rd_acc = s_req_o.valid && s_resp_i.ready && (s_req_o.wstrb == '0);

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         owner_q <= 1'b0;
      end else if (s_rd_acc) begin
         owner_q <= hi_sel;
      end
   end

   // loser sees ready low and keeps its request
   always_comb begin
      hi_resp_o.rdata  = s_resp_i.rdata;
      hi_resp_o.rvalid = s_resp_i.rvalid && owner_q;
      hi_resp_o.ready  = s_resp_i.ready && hi_sel;
      lo_resp_o.rdata  = s_resp_i.rdata;
      lo_resp_o.rvalid = s_resp_i.rvalid && !owner_q;
      lo_resp_o.ready  = s_resp_i.ready && !hi_sel;
   end

   // read data handed to the low master belongs to a read it issued
   a_lo_rvalid : assert property (@(posedge clk_i) disable iff (!rst_n_i)
      lo_resp_o.rvalid |-> $past(lo_req_i.valid && lo_resp_o.ready));

endmodule

// File: design/int_mem.sv
`timescale 1ns/1ns

module int_mem #(
   parameter int SRAM_ADDR_W    = 12,
   parameter int BOOTROM_ADDR_W = 8,
   parameter int B_BIT          = 31
) (
   input  logic                           clk_i,
   input  logic                           rst_n_i,
   input  int_mem_pkg::bus_req_t          i_req_i,
   input  int_mem_pkg::bus_req_t          d_req_i,
   input  logic [int_mem_pkg::DATA_W-1:0] rom_rdata_i,
   output int_mem_pkg::bus_resp_t         i_resp_o,
   output int_mem_pkg::bus_resp_t         d_resp_o,
   output logic                           boot_o,
   output logic                           cpu_rst_o,
   output logic                           rom_valid_o,
   output logic [BOOTROM_ADDR_W-3:0]      rom_addr_o
);
   import int_mem_pkg::*;

   localparam int SRAM_AW = SRAM_ADDR_W - 2;
   // word offset that puts CPU address 0 on the copied boot code
   localparam logic [SRAM_AW-1:0] BOOT_OFS =
      SRAM_AW'((2 ** SRAM_AW) - (2 ** (BOOTROM_ADDR_W - 2)));

   bus_req_t  ram_d_req;
   bus_resp_t ram_d_resp;
   bus_req_t  boot_reg_req;
   bus_resp_t boot_reg_resp;
   bus_req_t  boot_w_req;
   bus_resp_t boot_w_resp;
   bus_req_t  cpu_i_req;
   bus_req_t  sram_i_bus;
   bus_resp_t sram_i_resp;
   bus_req_t  sram_i_req;
   bus_req_t  sram_d_req;

   // sram word index of a byte address, optionally moved by the boot offset
   function automatic logic [SRAM_AW-1:0] sram_word(input logic [ADDR_W-1:0] addr,
                                                    input logic              remap);
      logic [SRAM_AW-1:0] w;
      w = addr[SRAM_ADDR_W-1:2];
      return remap ? w + BOOT_OFS : w;
   endfunction

   // data bus goes to the sram below B_BIT and to the boot register above
   bus_split #(
      .B_BIT(B_BIT)
   ) u_bus_split (
      .clk_i    (clk_i),
      .rst_n_i  (rst_n_i),
      .m_req_i  (d_req_i),
      .s0_resp_i(ram_d_resp),
      .s1_resp_i(boot_reg_resp),
      .m_resp_o (d_resp_o),
      .s0_req_o (ram_d_req),
      .s1_req_o (boot_reg_req)
   );

   boot_ctrl #(
      .SRAM_ADDR_W   (SRAM_ADDR_W),
      .BOOTROM_ADDR_W(BOOTROM_ADDR_W)
   ) u_boot_ctrl (
      .clk_i      (clk_i),
      .rst_n_i    (rst_n_i),
      .cpu_req_i  (boot_reg_req),
      .rom_rdata_i(rom_rdata_i),
      .cpu_resp_o (boot_reg_resp),
      .sram_req_o (boot_w_req),
      .rom_valid_o(rom_valid_o),
      .rom_addr_o (rom_addr_o),
      .boot_o     (boot_o),
      .cpu_rst_o  (cpu_rst_o)
   );

   // instruction fetches see the boot image at 0 while boot is set
   always_comb begin
      cpu_i_req      = i_req_i;
      cpu_i_req.addr = '0;
      cpu_i_req.addr[SRAM_ADDR_W-1:0] = {sram_word(i_req_i.addr, boot_o), i_req_i.addr[1:0]};
   end

   // boot writes go ahead of instruction fetches
   ibus_merge u_ibus_merge (
      .clk_i    (clk_i),
      .rst_n_i  (rst_n_i),
      .hi_req_i (boot_w_req),
      .lo_req_i (cpu_i_req),
      .s_resp_i (sram_i_resp),
      .hi_resp_o(boot_w_resp),
      .lo_resp_o(i_resp_o),
      .s_req_o  (sram_i_bus)
   );

   // word addresses for the sram with the data side remapped like fetches
   always_comb begin
      sram_i_req      = sram_i_bus;
      sram_i_req.addr = ADDR_W'(sram_word(sram_i_bus.addr, 1'b0));
      sram_d_req      = ram_d_req;
      sram_d_req.addr = ADDR_W'(sram_word(ram_d_req.addr, boot_o));
   end

   dp_sram #(
      .SRAM_ADDR_W(SRAM_ADDR_W)
   ) u_dp_sram (
      .clk_i   (clk_i),
      .rst_n_i (rst_n_i),
      .i_req_i (sram_i_req),
      .d_req_i (sram_d_req),
      .i_resp_o(sram_i_resp),
      .d_resp_o(ram_d_resp)
   );

   // the boot image must fit below the sram size
   a_rom_fits : assert property (@(posedge clk_i) BOOTROM_ADDR_W < SRAM_ADDR_W);

   // copy never stalls, so merge and sram must always take boot writes
   a_boot_wr_ready : assert property (@(posedge clk_i) disable iff (!rst_n_i)
      boot_w_req.valid |-> boot_w_resp.ready);

endmodule

// File: design/int_mem_pkg.sv
package int_mem_pkg;

   // bus widths shared by every block of the memory subsystem
   localparam int DATA_W = 32;
   localparam int ADDR_W = 32;
   localparam int STRB_W = DATA_W / 8;

   // master to slave request
   // a read carries wstrb all zero
   typedef struct packed {
      logic              valid;
      logic [ADDR_W-1:0] addr;
      logic [DATA_W-1:0] wdata;
      logic [STRB_W-1:0] wstrb;
   } bus_req_t;

   // slave to master response
   // rdata is valid together with rvalid, one cycle after acceptance
   typedef struct packed {
      logic [DATA_W-1:0] rdata;
      logic              rvalid;
      logic              ready;
   } bus_resp_t;

endpackage

// File: filelist.f
design/int_mem_pkg.sv
design/bus_split.sv
design/boot_ctrl.sv
design/ibus_merge.sv
design/dp_sram.sv
design/int_mem.sv
tests/int_mem_tb.sv

// File: tests/int_mem_tb.sv
`timescale 1ns/1ns

module int_mem_tb;
   import int_mem_pkg::*;

   localparam int SRAM_ADDR_W    = 12;
   localparam int BOOTROM_ADDR_W = 8;
   localparam int B_BIT          = 31;
   localparam int ROM_AW         = BOOTROM_ADDR_W - 2;
   localparam int ROM_WORDS      = 2 ** ROM_AW;
   localparam int TDAT_LEN       = 256;

   logic                      clk_i;
   logic                      rst_n_i;
   bus_req_t                  i_req_i;
   bus_req_t                  d_req_i;
   logic [DATA_W-1:0]         rom_rdata_i;
   bus_resp_t                 i_resp_o;
   bus_resp_t                 d_resp_o;
   logic                      boot_o;
   logic                      cpu_rst_o;
   logic                      rom_valid_o;
   logic [BOOTROM_ADDR_W-3:0] rom_addr_o;

   logic [31:0]               tdat [TDAT_LEN];
   logic [DATA_W-1:0]         rom_img [ROM_WORDS];
   logic                      rom_hit;
   logic [BOOTROM_ADDR_W-3:0] rom_word;
   int                        rom_n;
   int                        rec_n;
   int                        limit_cycles = 0;
   integer                    seed;

   int_mem #(
      .SRAM_ADDR_W   (SRAM_ADDR_W),
      .BOOTROM_ADDR_W(BOOTROM_ADDR_W),
      .B_BIT         (B_BIT)
   ) u_int_mem (
      .clk_i      (clk_i),
      .rst_n_i    (rst_n_i),
      .i_req_i    (i_req_i),
      .d_req_i    (d_req_i),
      .rom_rdata_i(rom_rdata_i),
      .i_resp_o   (i_resp_o),
      .d_resp_o   (d_resp_o),
      .boot_o     (boot_o),
      .cpu_rst_o  (cpu_rst_o),
      .rom_valid_o(rom_valid_o),
      .rom_addr_o (rom_addr_o)
   );

   always #5 clk_i = ~clk_i;

   // boot rom model answers in the cycle after rom_valid_o
   always @(posedge clk_i) begin
      rom_hit  = rom_valid_o;
      rom_word = rom_addr_o;
   end

   always @(negedge clk_i) begin
      if (rom_hit === 1'b1) begin
         rom_rdata_i = rom_img[rom_word];
      end
   end

   task automatic stop_run();
      $display("*** TEST FAILED ***");
      $fatal(1, "stopped at first error");
   endtask

   task automatic report_error(input string why);
      $display("ERROR at t=%0t: %s", $time, why);
      stop_run();
   endtask

   task automatic check_bit(input string name, input logic exp_bit, input logic got_bit);
      if (got_bit !== exp_bit) begin
         $display("[FAIL] t=%0t %s expected %b got %b", $time, name, exp_bit, got_bit);
         stop_run();
      end
   endtask

   task automatic check_rom_addr(input logic [BOOTROM_ADDR_W-3:0] exp_addr,
                                 input logic [BOOTROM_ADDR_W-3:0] got_addr);
      if (got_addr !== exp_addr) begin
         $display("[FAIL] t=%0t rom_addr_o expected %h got %h", $time, exp_addr, got_addr);
         stop_run();
      end
   endtask

   task automatic check_resp(input string name, input bus_resp_t got,
                             input logic [DATA_W-1:0] exp_rdata);
      check_bit({name, ".rvalid"}, 1'b1, got.rvalid);
      if (got.rdata !== exp_rdata) begin
         $display("[FAIL] t=%0t %s.rdata expected %h got %h", $time, name, exp_rdata, got.rdata);
         stop_run();
      end
   endtask

   // cpu reset held for 4 cycles while boot_o shows bit 0 of the write
   task automatic check_boot_pulse(input logic boot_val);
      repeat (4) begin
         @(posedge clk_i);
         check_bit("cpu_rst_o", 1'b1, cpu_rst_o);
         check_bit("boot_o", boot_val, boot_o);
      end
      @(posedge clk_i);
      check_bit("cpu_rst_o", 1'b0, cpu_rst_o);
   endtask

   // one transfer on either cpu bus with read data checked one cycle after acceptance
   task automatic run_access(input logic on_d, input logic is_wr, input logic [ADDR_W-1:0] addr,
                             input logic [DATA_W-1:0] wdata, input logic [STRB_W-1:0] strb,
                             input logic [DATA_W-1:0] exp_rdata);
      bus_req_t  req;
      bus_resp_t resp;
      string     resp_name;
      logic      acc;
      req.valid = 1'b1;
      req.addr  = addr;
      req.wdata = is_wr ? wdata : '0;
      req.wstrb = is_wr ? strb : '0;
      resp_name = on_d ? "d_resp_o" : "i_resp_o";
      @(negedge clk_i);
      if (on_d) begin
         d_req_i = req;
      end else begin
         i_req_i = req;
      end
      acc = 1'b0;
      while (!acc) begin
         @(posedge clk_i);
         resp = on_d ? d_resp_o : i_resp_o;
         acc  = resp.ready;
      end
      check_bit({resp_name, ".rvalid"}, 1'b0, resp.rvalid);
      @(negedge clk_i);
      i_req_i = '0;
      d_req_i = '0;
      if (!is_wr) begin
         @(posedge clk_i);
         check_resp(resp_name, on_d ? d_resp_o : i_resp_o, exp_rdata);
      end else if (on_d && addr[B_BIT]) begin
         check_boot_pulse(wdata[0]);
      end
   endtask

   initial begin
      wait (limit_cycles > 0);
      repeat (limit_cycles) @(posedge clk_i);
      report_error($sformatf("watchdog expired after %0d cycles", limit_cycles));
   end

   initial begin
      int   base;
      int   idx;
      int   gap;
      int   copy_edges;
      logic accepted;
      clk_i       = 1'b0;
      rst_n_i     = 1'b0;
      i_req_i     = '0;
      d_req_i     = '0;
      rom_rdata_i = '0;
      rom_hit     = 1'b0;
      seed        = 32'hfcd36232;
      $readmemh("tests/int_mem_tests.txt", tdat);
      if ($isunknown(tdat[0])) begin
         report_error("tests/int_mem_tests.txt could not be read");
      end
      rom_n = tdat[0];
      if (rom_n != ROM_WORDS) begin
         report_error($sformatf("data file gives %0d rom words, rom has %0d", rom_n, ROM_WORDS));
      end
      for (int k = 0; k < ROM_WORDS; k++) begin
         rom_img[k] = tdat[1 + k];
      end
      rec_n        = tdat[rom_n + 1];
      base         = rom_n + 2;
      limit_cycles = 20 * (rom_n + rec_n);

      repeat (8) @(posedge clk_i);
      @(negedge clk_i);
      rst_n_i = 1'b1;

      // fetch of address 0 is held across the whole copy
      copy_edges = 0;
      accepted   = 1'b0;
      while (!accepted) begin
         @(posedge clk_i);
         copy_edges++;
         check_bit("boot_o", 1'b1, boot_o);
         // one rom read per cycle, last write one cycle later, then release
         check_bit("rom_valid_o", copy_edges <= rom_n, rom_valid_o);
         if (rom_valid_o) begin
            check_rom_addr(ROM_AW'(copy_edges - 1), rom_addr_o);
         end
         check_bit("cpu_rst_o", copy_edges <= rom_n + 1, cpu_rst_o);
         if (i_req_i.valid) begin
            check_bit("i_resp_o.ready", copy_edges > rom_n + 1, i_resp_o.ready);
            check_bit("i_resp_o.rvalid", 1'b0, i_resp_o.rvalid);
            accepted = i_resp_o.ready;
         end
         @(negedge clk_i);
         if (accepted) begin
            i_req_i = '0;
         end else if (copy_edges == 2) begin
            i_req_i.valid = 1'b1;
         end
      end
      @(posedge clk_i);
      check_resp("i_resp_o", i_resp_o, rom_img[0]);

      // boot image seen at 0 through the remap
      for (int k = 0; k < rom_n; k++) begin
         run_access(1'b0, 1'b0, ADDR_W'(4 * k), '0, '0, rom_img[k]);
      end

      for (int r = 0; r < rec_n; r++) begin
         idx = base + 6 * r;
         gap = $unsigned($random(seed)) % 4;
         repeat (gap) @(negedge clk_i);
         run_access(tdat[idx][0], tdat[idx + 1][0], tdat[idx + 2], tdat[idx + 3],
                    STRB_W'(tdat[idx + 4]), tdat[idx + 5]);
      end

      repeat (2) @(negedge clk_i);
      $display("*** TEST PASSED ***");
      $finish;
   end

endmodule

// File: tests/int_mem_tests.txt
// rom word count, the rom words eight per line, then the record count
// records: bus (0 fetch, 1 data), op (0 read, 1 write), byte address, wdata, wstrb, expected rdata
40
b00700ff b00701fe b00702fd b00703fc b00704fb b00705fa b00706f9 b00707f8
b00708f7 b00709f6 b0070af5 b0070bf4 b0070cf3 b0070df2 b0070ef1 b0070ff0
b00710ef b00711ee b00712ed b00713ec b00714eb b00715ea b00716e9 b00717e8
b00718e7 b00719e6 b0071ae5 b0071be4 b0071ce3 b0071de2 b0071ee1 b0071fe0
b00720df b00721de b00722dd b00723dc b00724db b00725da b00726d9 b00727d8
b00728d7 b00729d6 b0072ad5 b0072bd4 b0072cd3 b0072dd2 b0072ed1 b0072fd0
b00730cf b00731ce b00732cd b00733cc b00734cb b00735ca b00736c9 b00737c8
b00738c7 b00739c6 b0073ac5 b0073bc4 b0073cc3 b0073dc2 b0073ec1 b0073fc0
12
// boot set, data side sees the rom image at 0
1 0 00000000 00000000 0 b00700ff
1 0 000000fc 00000000 0 b0073fc0
1 0 80000000 00000000 0 00000001
// partial strobes merge with the earlier word
1 1 00000104 11223344 f 00000000
1 1 00000104 aabbccdd 5 00000000
1 0 00000104 00000000 0 11bb33dd
1 1 00000108 cafef00d f 00000000
1 1 00000108 5a000000 8 00000000
1 0 00000108 00000000 0 5afef00d
// 0x100 wraps to sram word 0 while boot is set
1 1 00000100 600df00d f 00000000
0 0 00000104 00000000 0 11bb33dd
// boot off, remap gone
1 1 80000000 00000000 f 00000000
1 0 80000000 00000000 0 00000000
0 0 00000f00 00000000 0 b00700ff
1 0 00000ffc 00000000 0 b0073fc0
0 0 00000000 00000000 0 600df00d
1 0 00000000 00000000 0 600df00d
0 0 00000f04 00000000 0 b00701fe
